//--- rtl/fpu_pkg.sv
package fpu_pkg;

    // data shape of one request
    localparam int NUM_THREADS = 2;
    localparam int FLEN        = 32;
    localparam int EXP_BITS    = 8;
    localparam int MAN_BITS    = 23;
    localparam int TAG_BITS    = 4;
    localparam int FRM_BITS    = 3;

    // lane depths and arbiter priority order, lowest index wins
    localparam int LATENCY_SIGN      = 1;
    localparam int LATENCY_CLASS_CMP = 2;
    localparam int NUM_LANES         = 2;
    localparam int LANE_SIGN         = 0;
    localparam int LANE_CLASS_CMP    = 1;

    typedef enum logic [1:0] {
        OP_SGNJ,
        OP_MV,
        OP_CLASS,
        OP_CMP
    } fpu_op_e;

    typedef enum logic [2:0] {
        FN_SGNJ,
        FN_SGNJN,
        FN_SGNJX,
        FN_MOVE,
        FN_CLASS,
        FN_FLE,
        FN_FLT,
        FN_FEQ
    } ncp_func_e;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    localparam int FLAG_NV = 4;

    // one-hot positions of the fclass result
    localparam int CLASS_BITS     = 10;
    localparam int CLASS_NEG_INF  = 0;
    localparam int CLASS_NEG_NORM = 1;
    localparam int CLASS_NEG_SUB  = 2;
    localparam int CLASS_NEG_ZERO = 3;
    localparam int CLASS_POS_ZERO = 4;
    localparam int CLASS_POS_SUB  = 5;
    localparam int CLASS_POS_NORM = 6;
    localparam int CLASS_POS_INF  = 7;
    localparam int CLASS_SNAN     = 8;
    localparam int CLASS_QNAN     = 9;

    // payload widths of the two lane pipes
    localparam int SIGN_PIPE_BITS = TAG_BITS + NUM_THREADS * FLEN;
    localparam int CMP_PIPE_BITS  = TAG_BITS + 1 + NUM_THREADS * (FLEN + $bits(fflags_t));

endpackage

//--- rtl/fpu_op_decode.sv
`timescale 1ns/1ps

module fpu_op_decode (
    input  logic                         valid_in,
    input  fpu_pkg::fpu_op_e             op_type,
    input  logic [fpu_pkg::FRM_BITS-1:0] frm,
    input  logic                         sign_ready,
    input  logic                         class_cmp_ready,
    output logic                         sign_valid,
    output logic                         class_cmp_valid,
    output fpu_pkg::ncp_func_e           func,
    output logic                         ready_in
);

    logic to_class_cmp;

    always_comb begin
        func         = fpu_pkg::FN_MOVE;
        to_class_cmp = 1'b0;
        case (op_type)
            fpu_pkg::OP_SGNJ: begin
                case (frm)
                    3'd0:    func = fpu_pkg::FN_SGNJ;
                    3'd1:    func = fpu_pkg::FN_SGNJN;
                    3'd2:    func = fpu_pkg::FN_SGNJX;
                    default: func = fpu_pkg::FN_MOVE;
                endcase
            end
            fpu_pkg::OP_MV: begin
                func = fpu_pkg::FN_MOVE;
            end
            fpu_pkg::OP_CLASS: begin
                func         = fpu_pkg::FN_CLASS;
                to_class_cmp = 1'b1;
            end
            default: begin
                // unknown compare modifiers fall back to a move in the compare lane
                to_class_cmp = 1'b1;
                case (frm)
                    3'd0:    func = fpu_pkg::FN_FLE;
                    3'd1:    func = fpu_pkg::FN_FLT;
                    3'd2:    func = fpu_pkg::FN_FEQ;
                    default: func = fpu_pkg::FN_MOVE;
                endcase
            end
        endcase
    end

    assign sign_valid      = valid_in & ~to_class_cmp;
    assign class_cmp_valid = valid_in & to_class_cmp;

    // selected lane accepts in the same cycle its pipe advances
    assign ready_in = to_class_cmp ? class_cmp_ready : sign_ready;

endmodule

//--- rtl/fpu_latency_pipe.sv
`timescale 1ns/1ps

module fpu_latency_pipe #(
    parameter int DEPTH     = 1,
    parameter int DATA_BITS = 1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  logic [DATA_BITS-1:0] in_data,
    output logic                 in_ready,
    output logic                 out_valid,
    output logic [DATA_BITS-1:0] out_data,
    input  logic                 out_ready
);

    logic [DEPTH-1:0]                valid_q;
    logic [DEPTH-1:0][DATA_BITS-1:0] data_q;
    logic                            enable;

    // whole pipe moves when the last stage drains or is empty
    assign enable = out_ready | ~valid_q[DEPTH-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            data_q[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end
    end

    assign in_ready  = enable;
    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

//--- rtl/fpu_sign_lane.sv
`timescale 1ns/1ps

module fpu_sign_lane (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 in_valid,
    input  fpu_pkg::ncp_func_e                                   func,
    input  logic [fpu_pkg::TAG_BITS-1:0]                         tag_in,
    input  logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   dataa,
    input  logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   datab,
    output logic                                                 in_ready,
    output logic                                                 out_valid,
    output logic [fpu_pkg::TAG_BITS-1:0]                         out_tag,
    output logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   out_result,
    input  logic                                                 out_ready
);

    localparam int MSB = fpu_pkg::FLEN - 1;

    logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0] lane_result;
    logic [fpu_pkg::SIGN_PIPE_BITS-1:0]                 pipe_out;

    // only the sign bit changes, the magnitude always comes from dataa
    always_comb begin
        for (int t = 0; t < fpu_pkg::NUM_THREADS; t++) begin
            case (func)
                fpu_pkg::FN_SGNJ:  lane_result[t] = {datab[t][MSB], dataa[t][MSB-1:0]};
                fpu_pkg::FN_SGNJN: lane_result[t] = {~datab[t][MSB], dataa[t][MSB-1:0]};
                fpu_pkg::FN_SGNJX: begin
                    lane_result[t] = {dataa[t][MSB] ^ datab[t][MSB], dataa[t][MSB-1:0]};
                end
                default:           lane_result[t] = dataa[t];
            endcase
        end
    end

    fpu_latency_pipe #(
        .DEPTH     (fpu_pkg::LATENCY_SIGN),
        .DATA_BITS (fpu_pkg::SIGN_PIPE_BITS)
    ) u_pipe (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   ({tag_in, lane_result}),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (pipe_out),
        .out_ready (out_ready)
    );

    assign {out_tag, out_result} = pipe_out;

endmodule

//--- rtl/fpu_class_cmp_lane.sv
`timescale 1ns/1ps

module fpu_class_cmp_lane (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 in_valid,
    input  fpu_pkg::ncp_func_e                                   func,
    input  logic [fpu_pkg::TAG_BITS-1:0]                         tag_in,
    input  logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   dataa,
    input  logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   datab,
    output logic                                                 in_ready,
    output logic                                                 out_valid,
    output logic [fpu_pkg::TAG_BITS-1:0]                         out_tag,
    output logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   out_result,
    output logic                                                 out_has_fflags,
    output fpu_pkg::fflags_t [fpu_pkg::NUM_THREADS-1:0]          out_fflags,
    input  logic                                                 out_ready
);

    localparam int MSB = fpu_pkg::FLEN - 1;

    logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0] lane_result;
    fpu_pkg::fflags_t [fpu_pkg::NUM_THREADS-1:0]        lane_fflags;
    logic                                               lane_has_fflags;
    logic [fpu_pkg::CMP_PIPE_BITS-1:0]                  pipe_out;

    // one-hot class of a single-precision value
    function automatic logic [fpu_pkg::CLASS_BITS-1:0] classify(input logic [MSB:0] x);
        logic                          sign;
        logic                          exp_max;
        logic                          exp_zero;
        logic                          man_zero;
        logic [fpu_pkg::CLASS_BITS-1:0] cls;
        sign     = x[MSB];
        exp_max  = &x[MSB-1 -: fpu_pkg::EXP_BITS];
        exp_zero = ~|x[MSB-1 -: fpu_pkg::EXP_BITS];
        man_zero = ~|x[fpu_pkg::MAN_BITS-1:0];
        cls      = '0;
        if (exp_max && !man_zero) begin
            // top mantissa bit tells quiet from signaling
            if (x[fpu_pkg::MAN_BITS-1]) begin
                cls[fpu_pkg::CLASS_QNAN] = 1'b1;
            end else begin
                cls[fpu_pkg::CLASS_SNAN] = 1'b1;
            end
        end else if (exp_max) begin
            cls[sign ? fpu_pkg::CLASS_NEG_INF : fpu_pkg::CLASS_POS_INF] = 1'b1;
        end else if (exp_zero && man_zero) begin
            cls[sign ? fpu_pkg::CLASS_NEG_ZERO : fpu_pkg::CLASS_POS_ZERO] = 1'b1;
        end else if (exp_zero) begin
            cls[sign ? fpu_pkg::CLASS_NEG_SUB : fpu_pkg::CLASS_POS_SUB] = 1'b1;
        end else begin
            cls[sign ? fpu_pkg::CLASS_NEG_NORM : fpu_pkg::CLASS_POS_NORM] = 1'b1;
        end
        return cls;
    endfunction

    for (genvar t = 0; t < fpu_pkg::NUM_THREADS; t++) begin : g_thread
        logic [fpu_pkg::CLASS_BITS-1:0] cls_a;
        logic [fpu_pkg::CLASS_BITS-1:0] cls_b;
        logic                           any_nan;
        logic                           any_snan;
        logic                           both_zero;
        logic                           a_lt_b;
        logic                           a_eq_b;

        assign cls_a = classify(dataa[t]);
        assign cls_b = classify(datab[t]);

        assign any_snan  = cls_a[fpu_pkg::CLASS_SNAN] | cls_b[fpu_pkg::CLASS_SNAN];
        assign any_nan   = any_snan | cls_a[fpu_pkg::CLASS_QNAN] | cls_b[fpu_pkg::CLASS_QNAN];
        assign both_zero = (cls_a[fpu_pkg::CLASS_NEG_ZERO] | cls_a[fpu_pkg::CLASS_POS_ZERO])
                         & (cls_b[fpu_pkg::CLASS_NEG_ZERO] | cls_b[fpu_pkg::CLASS_POS_ZERO]);

        // sign-magnitude ordering, magnitudes compare as plain integers
        assign a_lt_b = (dataa[t][MSB] != datab[t][MSB]) ? (dataa[t][MSB] & ~both_zero) :
                        dataa[t][MSB] ? (datab[t][MSB-1:0] < dataa[t][MSB-1:0]) :
                                        (dataa[t][MSB-1:0] < datab[t][MSB-1:0]);
        assign a_eq_b = both_zero | (dataa[t] == datab[t]);

        always_comb begin
            lane_result[t] = dataa[t];
            lane_fflags[t] = '0;
            case (func)
                fpu_pkg::FN_CLASS: begin
                    lane_result[t] = {{(fpu_pkg::FLEN - fpu_pkg::CLASS_BITS){1'b0}}, cls_a};
                end
                fpu_pkg::FN_FLE: begin
                    lane_result[t] = {{MSB{1'b0}}, ~any_nan & (a_lt_b | a_eq_b)};
                    lane_fflags[t][fpu_pkg::FLAG_NV] = any_nan;
                end
                fpu_pkg::FN_FLT: begin
                    lane_result[t] = {{MSB{1'b0}}, ~any_nan & a_lt_b};
                    lane_fflags[t][fpu_pkg::FLAG_NV] = any_nan;
                end
                fpu_pkg::FN_FEQ: begin
                    // quiet compare, only a signaling NaN is invalid
                    lane_result[t] = {{MSB{1'b0}}, ~any_nan & a_eq_b};
                    lane_fflags[t][fpu_pkg::FLAG_NV] = any_snan;
                end
                default: begin
                    lane_result[t] = dataa[t];
                end
            endcase
        end
    end

    assign lane_has_fflags = (func == fpu_pkg::FN_FLE) || (func == fpu_pkg::FN_FLT)
                          || (func == fpu_pkg::FN_FEQ);

    fpu_latency_pipe #(
        .DEPTH     (fpu_pkg::LATENCY_CLASS_CMP),
        .DATA_BITS (fpu_pkg::CMP_PIPE_BITS)
    ) u_pipe (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   ({tag_in, lane_has_fflags, lane_result, lane_fflags}),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (pipe_out),
        .out_ready (out_ready)
    );

    assign {out_tag, out_has_fflags, out_result, out_fflags} = pipe_out;

endmodule

//--- rtl/fpu_result_arbiter.sv
`timescale 1ns/1ps

module fpu_result_arbiter (
    input  logic                                                 sign_valid,
    input  logic [fpu_pkg::TAG_BITS-1:0]                         sign_tag,
    input  logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   sign_result,
    input  logic                                                 cmp_valid,
    input  logic [fpu_pkg::TAG_BITS-1:0]                         cmp_tag,
    input  logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   cmp_result,
    input  logic                                                 cmp_has_fflags,
    input  fpu_pkg::fflags_t [fpu_pkg::NUM_THREADS-1:0]          cmp_fflags,
    input  logic                                                 ready_out,
    output logic                                                 sign_ready,
    output logic                                                 cmp_ready,
    output logic                                                 valid_out,
    output logic [fpu_pkg::TAG_BITS-1:0]                         tag_out,
    output logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   result,
    output logic                                                 has_fflags,
    output fpu_pkg::fflags_t [fpu_pkg::NUM_THREADS-1:0]          fflags
);

    logic [fpu_pkg::NUM_LANES-1:0] lane_valid;
    logic [fpu_pkg::NUM_LANES-1:0] lane_grant;
    logic [fpu_pkg::NUM_LANES-1:0] lane_ready;
    logic                          sel_sign;

    assign lane_valid[fpu_pkg::LANE_SIGN]      = sign_valid;
    assign lane_valid[fpu_pkg::LANE_CLASS_CMP] = cmp_valid;

    // lowest set valid bit wins
    assign lane_grant = lane_valid & ~(lane_valid - 1'b1);
    assign lane_ready = lane_grant & {fpu_pkg::NUM_LANES{ready_out}};

    assign sign_ready = lane_ready[fpu_pkg::LANE_SIGN];
    assign cmp_ready  = lane_ready[fpu_pkg::LANE_CLASS_CMP];
    assign sel_sign   = lane_grant[fpu_pkg::LANE_SIGN];

    assign valid_out  = |lane_valid;
    assign tag_out    = sel_sign ? sign_tag : cmp_tag;
    assign result     = sel_sign ? sign_result : cmp_result;
    // sign results never carry flags
    assign has_fflags = sel_sign ? 1'b0 : cmp_has_fflags;
    assign fflags     = sel_sign ? '0 : cmp_fflags;

endmodule

//--- rtl/fpu_ncp_unit.sv
`timescale 1ns/1ps

module fpu_ncp_unit (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 valid_in,
    input  fpu_pkg::fpu_op_e                                     op_type,
    input  logic [fpu_pkg::FRM_BITS-1:0]                         frm,
    input  logic [fpu_pkg::TAG_BITS-1:0]                         tag_in,
    input  logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   dataa,
    input  logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   datab,
    output logic                                                 ready_in,
    output logic                                                 valid_out,
    output logic [fpu_pkg::TAG_BITS-1:0]                         tag_out,
    output logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0]   result,
    output logic                                                 has_fflags,
    output fpu_pkg::fflags_t [fpu_pkg::NUM_THREADS-1:0]          fflags,
    input  logic                                                 ready_out
);

    fpu_pkg::ncp_func_e                                 func;
    logic                                               sign_in_valid;
    logic                                               sign_in_ready;
    logic                                               sign_req_valid;
    logic                                               sign_req_ready;
    logic                                               cmp_stalled;
    logic                                               sign_out_valid;
    logic                                               sign_out_ready;
    logic [fpu_pkg::TAG_BITS-1:0]                       sign_tag;
    logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0] sign_result;
    logic                                               cmp_in_valid;
    logic                                               cmp_in_ready;
    logic                                               cmp_out_valid;
    logic                                               cmp_out_ready;
    logic [fpu_pkg::TAG_BITS-1:0]                       cmp_tag;
    logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0] cmp_result;
    logic                                               cmp_has_fflags;
    fpu_pkg::fflags_t [fpu_pkg::NUM_THREADS-1:0]        cmp_fflags;

    // a lone stalled compare result keeps the port until it transfers
    // so the sign lane takes no request that would overtake it meanwhile
    assign cmp_stalled    = cmp_out_valid & ~sign_out_valid & ~ready_out;
    assign sign_req_ready = sign_in_ready & ~cmp_stalled;
    assign sign_req_valid = sign_in_valid & ~cmp_stalled;

    fpu_op_decode u_decode (
        .valid_in        (valid_in),
        .op_type         (op_type),
        .frm             (frm),
        .sign_ready      (sign_req_ready),
        .class_cmp_ready (cmp_in_ready),
        .sign_valid      (sign_in_valid),
        .class_cmp_valid (cmp_in_valid),
        .func            (func),
        .ready_in        (ready_in)
    );

    fpu_sign_lane u_sign_lane (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (sign_req_valid),
        .func       (func),
        .tag_in     (tag_in),
        .dataa      (dataa),
        .datab      (datab),
        .in_ready   (sign_in_ready),
        .out_valid  (sign_out_valid),
        .out_tag    (sign_tag),
        .out_result (sign_result),
        .out_ready  (sign_out_ready)
    );

    fpu_class_cmp_lane u_class_cmp_lane (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (cmp_in_valid),
        .func           (func),
        .tag_in         (tag_in),
        .dataa          (dataa),
        .datab          (datab),
        .in_ready       (cmp_in_ready),
        .out_valid      (cmp_out_valid),
        .out_tag        (cmp_tag),
        .out_result     (cmp_result),
        .out_has_fflags (cmp_has_fflags),
        .out_fflags     (cmp_fflags),
        .out_ready      (cmp_out_ready)
    );

    fpu_result_arbiter u_arbiter (
        .sign_valid     (sign_out_valid),
        .sign_tag       (sign_tag),
        .sign_result    (sign_result),
        .cmp_valid      (cmp_out_valid),
        .cmp_tag        (cmp_tag),
        .cmp_result     (cmp_result),
        .cmp_has_fflags (cmp_has_fflags),
        .cmp_fflags     (cmp_fflags),
        .ready_out      (ready_out),
        .sign_ready     (sign_out_ready),
        .cmp_ready      (cmp_out_ready),
        .valid_out      (valid_out),
        .tag_out        (tag_out),
        .result         (result),
        .has_fflags     (has_fflags),
        .fflags         (fflags)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int PERIOD_NS    = 100;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset spans two rising edges and drops on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- dv/fpu_ncp_properties.sv
`timescale 1ns/1ps

module fpu_ncp_properties (
    input logic                                               clk,
    input logic                                               reset,
    input logic                                               ready_in,
    input logic                                               valid_out,
    input logic                                               ready_out,
    input logic [fpu_pkg::TAG_BITS-1:0]                       tag_out,
    input logic [fpu_pkg::NUM_THREADS-1:0][fpu_pkg::FLEN-1:0] result,
    input logic                                               has_fflags,
    input fpu_pkg::fflags_t [fpu_pkg::NUM_THREADS-1:0]        fflags
);

    // pipes come out of reset empty
    valid_low_after_reset: assert property (@(posedge clk) reset |=> !valid_out)
        else $error("valid_out high in the cycle after reset");

    // a stalled result keeps its tag and data
    result_holds_on_stall: assert property (@(posedge clk) disable iff (reset)
        valid_out && !ready_out |=> valid_out && $stable(tag_out) && $stable(result))
        else $error("result port changed while stalled");

    // compares only produce 0 or 1 unless the operation was invalid
    for (genvar t = 0; t < fpu_pkg::NUM_THREADS; t++) begin : g_flag_check
        flagged_result_is_boolean: assert property (@(posedge clk) disable iff (reset)
            valid_out && has_fflags |-> fflags[t][fpu_pkg::FLAG_NV] || result[t] <= 1)
            else $error("flagged result above 1 without NV on thread %0d", t);
    end

    ready_in_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(ready_in))
        else $error("ready_in is unknown");

endmodule

bind fpu_ncp_unit fpu_ncp_properties u_properties (
    .clk        (clk),
    .reset      (reset),
    .ready_in   (ready_in),
    .valid_out  (valid_out),
    .ready_out  (ready_out),
    .tag_out    (tag_out),
    .result     (result),
    .has_fflags (has_fflags),
    .fflags     (fflags)
);

//--- dv/fpu_ncp_tb.sv
`timescale 1ns/1ps

module fpu_ncp_tb;

    localparam int NT       = fpu_pkg::NUM_THREADS;
    localparam int FLEN     = fpu_pkg::FLEN;
    localparam int NUM_ROWS = 16;
    // 16 rows x 2 lanes x ~8 stall cycles, plus reset and drain margin
    localparam int MAX_CYCLES = 400;

    logic                                  clk;
    logic                                  reset;
    logic                                  valid_in;
    fpu_pkg::fpu_op_e                      op_type;
    logic [fpu_pkg::FRM_BITS-1:0]          frm;
    logic [fpu_pkg::TAG_BITS-1:0]          tag_in;
    logic [NT-1:0][FLEN-1:0]               dataa;
    logic [NT-1:0][FLEN-1:0]               datab;
    logic                                  ready_in;
    logic                                  valid_out;
    logic [fpu_pkg::TAG_BITS-1:0]          tag_out;
    logic [NT-1:0][FLEN-1:0]               result;
    logic                                  has_fflags;
    fpu_pkg::fflags_t [NT-1:0]             fflags;
    logic                                  ready_out;

    // stimulus and expected values, thread 1 in the upper half
    fpu_pkg::fpu_op_e                      tbl_op  [NUM_ROWS];
    logic [2:0]                            tbl_frm [NUM_ROWS];
    logic [NT-1:0][FLEN-1:0]               tbl_a   [NUM_ROWS];
    logic [NT-1:0][FLEN-1:0]               tbl_b   [NUM_ROWS];
    logic [NT-1:0][FLEN-1:0]               tbl_res [NUM_ROWS];
    logic                                  tbl_hf  [NUM_ROWS];
    logic [NT-1:0][4:0]                    tbl_ff  [NUM_ROWS];

    logic                                  outstanding [NUM_ROWS];
    logic                                  returned    [NUM_ROWS];
    int                                    num_returned;
    int                                    reorder_count;
    int                                    error_count;
    int                                    cycle_count;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    fpu_ncp_unit DUT (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (valid_in),
        .op_type    (op_type),
        .frm        (frm),
        .tag_in     (tag_in),
        .dataa      (dataa),
        .datab      (datab),
        .ready_in   (ready_in),
        .valid_out  (valid_out),
        .tag_out    (tag_out),
        .result     (result),
        .has_fflags (has_fflags),
        .fflags     (fflags),
        .ready_out  (ready_out)
    );

    task automatic load_row(input int idx, input fpu_pkg::fpu_op_e op, input logic [2:0] f,
                            input logic [31:0] a0, input logic [31:0] a1,
                            input logic [31:0] b0, input logic [31:0] b1,
                            input logic [31:0] r0, input logic [31:0] r1,
                            input logic hf, input logic [4:0] f0, input logic [4:0] f1);
        tbl_op[idx]  = op;
        tbl_frm[idx] = f;
        tbl_a[idx]   = {a1, a0};
        tbl_b[idx]   = {b1, b0};
        tbl_res[idx] = {r1, r0};
        tbl_hf[idx]  = hf;
        tbl_ff[idx]  = {f1, f0};
    endtask

    // sign and compare rows interleave so sign results can overtake
    task automatic load_table();
        load_row(0, fpu_pkg::OP_SGNJ, 3'd0, 32'h3F800000, 32'hC0400000, 32'hBF800000,
                 32'h40000000, 32'hBF800000, 32'h40400000, 1'b0, 5'h00, 5'h00);
        load_row(1, fpu_pkg::OP_CLASS, 3'd0, 32'hFF800000, 32'hBF800000, 32'h0, 32'h0,
                 32'h001, 32'h002, 1'b0, 5'h00, 5'h00);
        load_row(2, fpu_pkg::OP_CMP, 3'd0, 32'h3F800000, 32'h80000000, 32'h40000000,
                 32'h00000000, 32'h1, 32'h1, 1'b1, 5'h00, 5'h00);
        load_row(3, fpu_pkg::OP_SGNJ, 3'd1, 32'h3F800000, 32'hC0400000, 32'h3F800000,
                 32'hC0000000, 32'hBF800000, 32'h40400000, 1'b0, 5'h00, 5'h00);
        load_row(4, fpu_pkg::OP_CLASS, 3'd0, 32'h80000001, 32'h80000000, 32'h0, 32'h0,
                 32'h004, 32'h008, 1'b0, 5'h00, 5'h00);
        // -2 < -1 on thread 0, negative quiet NaN on thread 1
        load_row(5, fpu_pkg::OP_CMP, 3'd1, 32'hC0000000, 32'hFFC00000, 32'hBF800000,
                 32'h00000000, 32'h1, 32'h0, 1'b1, 5'h00, 5'h10);
        load_row(6, fpu_pkg::OP_SGNJ, 3'd2, 32'hBF800000, 32'h3F800000, 32'hC0000000,
                 32'h80000000, 32'h3F800000, 32'hBF800000, 1'b0, 5'h00, 5'h00);
        load_row(7, fpu_pkg::OP_CLASS, 3'd0, 32'h00000000, 32'h00000001, 32'h0, 32'h0,
                 32'h010, 32'h020, 1'b0, 5'h00, 5'h00);
        load_row(8, fpu_pkg::OP_CMP, 3'd2, 32'h80000000, 32'h3F800000, 32'h00000000,
                 32'h3F800001, 32'h1, 32'h0, 1'b1, 5'h00, 5'h00);
        load_row(9, fpu_pkg::OP_MV, 3'd0, 32'h12345678, 32'hFEDCBA98, 32'hFFFFFFFF,
                 32'h00000000, 32'h12345678, 32'hFEDCBA98, 1'b0, 5'h00, 5'h00);
        load_row(10, fpu_pkg::OP_CLASS, 3'd0, 32'h3F800000, 32'h7F800000, 32'h0, 32'h0,
                 32'h040, 32'h080, 1'b0, 5'h00, 5'h00);
        load_row(11, fpu_pkg::OP_CMP, 3'd0, 32'h7FC00000, 32'h3F800000, 32'h3F800000,
                 32'h7F800001, 32'h0, 32'h0, 1'b1, 5'h10, 5'h10);
        load_row(12, fpu_pkg::OP_SGNJ, 3'd5, 32'h80000001, 32'h7F800000, 32'hFFFFFFFF,
                 32'hFFFFFFFF, 32'h80000001, 32'h7F800000, 1'b0, 5'h00, 5'h00);
        load_row(13, fpu_pkg::OP_CLASS, 3'd0, 32'h7F800001, 32'h7FC00000, 32'h0, 32'h0,
                 32'h100, 32'h200, 1'b0, 5'h00, 5'h00);
        // feq stays quiet on a quiet NaN
        load_row(14, fpu_pkg::OP_CMP, 3'd2, 32'h7FC00000, 32'h7F800001, 32'h7FC00000,
                 32'h3F800000, 32'h0, 32'h0, 1'b1, 5'h00, 5'h10);
        load_row(15, fpu_pkg::OP_CMP, 3'd3, 32'hDEADBEEF, 32'h0000CAFE, 32'h00000001,
                 32'h00000002, 32'hDEADBEEF, 32'h0000CAFE, 1'b0, 5'h00, 5'h00);
    endtask

    task automatic report_result();
        $display("results out of request order: %0d", reorder_count);
        $display("errors: %0d, results returned: %0d of %0d", error_count, num_returned,
                 NUM_ROWS);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
    endtask

    // back-pressure, high about half the time
    initial begin
        void'($urandom(37));
        ready_out = 1'b0;
        forever begin
            @(negedge clk);
            ready_out = ($urandom & 32'd1) != 32'd0;
        end
    end

    initial begin
        valid_in      = 1'b0;
        op_type       = fpu_pkg::OP_SGNJ;
        frm           = '0;
        tag_in        = '0;
        dataa         = '0;
        datab         = '0;
        num_returned  = 0;
        reorder_count = 0;
        error_count   = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            outstanding[i] = 1'b0;
            returned[i]    = 1'b0;
        end
        load_table();
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            valid_in = 1'b1;
            op_type  = tbl_op[i];
            frm      = tbl_frm[i];
            tag_in   = 4'(i);
            dataa    = tbl_a[i];
            datab    = tbl_b[i];
            @(posedge clk);
            while (!ready_in) begin
                @(posedge clk);
            end
            outstanding[i] = 1'b1;
            @(negedge clk);
        end
        valid_in = 1'b0;
        while (num_returned < NUM_ROWS) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        // a sign row behind a compare row must overtake it at least once
        if (reorder_count == 0) begin
            $display("no sign result overtook an earlier compare result");
            error_count++;
        end
        report_result();
        $finish;
    end

    // scoreboard on every result transfer
    always @(posedge clk) begin
        int                 idx;
        logic [NT-1:0][4:0] got_ff;
        if (!reset && valid_out && ready_out) begin
            got_ff = fflags;
            if ($isunknown(tag_out)) begin
                $display("result transferred with an unknown tag");
                error_count++;
            end else begin
                idx = int'(tag_out);
                if (idx != num_returned) begin
                    reorder_count++;
                end
                if (returned[idx]) begin
                    $display("tag %0d returned a second time", idx);
                    error_count++;
                end else if (!outstanding[idx]) begin
                    $display("tag %0d returned but was never sent", idx);
                    error_count++;
                end else begin
                    for (int t = 0; t < NT; t++) begin
                        if (result[t] !== tbl_res[idx][t]) begin
                            $display("ERR result[%0d] tag %0d: got %h expected %h", t, idx,
                                     result[t], tbl_res[idx][t]);
                            error_count++;
                        end
                        if (got_ff[t] !== tbl_ff[idx][t]) begin
                            $display("ERR fflags[%0d] tag %0d: got %h expected %h", t, idx,
                                     got_ff[t], tbl_ff[idx][t]);
                            error_count++;
                        end
                    end
                    if (has_fflags !== tbl_hf[idx]) begin
                        $display("ERR has_fflags tag %0d: got %h expected %h", idx,
                                 has_fflags, tbl_hf[idx]);
                        error_count++;
                    end
                    outstanding[idx] = 1'b0;
                    returned[idx]    = 1'b1;
                    num_returned++;
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        error_count++;
        report_result();
        $finish;
    end

endmodule

//--- src.f
rtl/fpu_pkg.sv
rtl/fpu_op_decode.sv
rtl/fpu_latency_pipe.sv
rtl/fpu_sign_lane.sv
rtl/fpu_class_cmp_lane.sv
rtl/fpu_result_arbiter.sv
rtl/fpu_ncp_unit.sv
dv/tb_clock_gen.sv
dv/fpu_ncp_properties.sv
dv/fpu_ncp_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILE_LIST ?= src.f
TOP       ?= fpu_ncp_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILE_LIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
